// File: Makefile
TOOL = verilator
FLAGS = --binary --timing --assert
TOP = periphTb
FILELIST = src.f
BUILD = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf $(BUILD)

// File: design/irqUnit.sv
module irqUnit (
	input  logic clk,
	input  logic reset,
	input  logic irqEnWrite,
	input  logic [periphPkg::irqCount-1:0] irqEnValue,
	input  logic rxValid,
	input  logic txReady,
	input  logic pwmIrq,
	output logic irq,
	output logic [1:0] irqId
);

	logic [periphPkg::irqCount-1:0] irqEn;		// Bit 0 rx, 1 tx, 2 pwm
	logic [periphPkg::irqCount-1:0] pending;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) irqEn <= '0;	// All sources masked
		else if (irqEnWrite) irqEn <= irqEnValue;
	end

	assign pending = {pwmIrq, txReady, rxValid} & irqEn;
	assign irq = |pending;

	// Lowest source number wins
	always_comb begin
		if (pending[0]) irqId = periphPkg::irqRx;
		else if (pending[1]) irqId = periphPkg::irqTx;
		else if (pending[2]) irqId = periphPkg::irqPwm;
		else irqId = 2'd0;
	end

	// Enable strobe from the bus lasts one cycle
	enWritePulse: assert property (@(posedge clk) disable iff (reset)
		irqEnWrite |=> !irqEnWrite);

endmodule

// File: design/periphPkg.sv
package periphPkg;

	// Register port geometry
	localparam int dataWidth = 8;	// One register word
	localparam int addrWidth = 2;	// Four registers

	////////////////////////////////////////////////////////////
	// Register offsets

	localparam logic [addrWidth-1:0] regData = 2'd0;		// Tx byte out or rx byte in
	localparam logic [addrWidth-1:0] regStatus = 2'd1;		// Read only
	localparam logic [addrWidth-1:0] regDuty = 2'd2;		// Pending PWM duty
	localparam logic [addrWidth-1:0] regIrqEnable = 2'd3;	// Source enables

	////////////////////////////////////////////////////////////
	// Status word bit positions

	localparam int stRxValid = 0;
	localparam int stTxReady = 1;
	localparam int stFrameErr = 2;	// Stop bit of last frame was 0
	localparam int stOverrun = 3;	// Frame lost before a read
	localparam int stPwmIrq = 4;

	////////////////////////////////////////////////////////////
	// Interrupt sources

	localparam int irqCount = 3;

	// Source numbers as seen on irqId, 0 means none
	localparam logic [1:0] irqRx = 2'd1;	// Highest priority
	localparam logic [1:0] irqTx = 2'd2;
	localparam logic [1:0] irqPwm = 2'd3;	// Lowest priority

endpackage

// File: design/periphTop.sv
module periphTop #(
	parameter int clkDiv = 217,	// Clocks per serial bit
	parameter int pwmMax = 180	// PWM terminal count
) (
	input  logic clk,
	input  logic reset,
	input  logic req,
	input  logic write,
	input  logic [periphPkg::addrWidth-1:0] addr,
	input  logic [periphPkg::dataWidth-1:0] wdata,
	output logic ack,
	output logic [periphPkg::dataWidth-1:0] rdata,
	input  logic rxd,
	output logic txd,
	output logic pwmOut,
	output logic irq,
	output logic [1:0] irqId
);

	////////////////////////////////////////////////////////////
	// Internal strobes and flags

	logic txWrite;
	logic [periphPkg::dataWidth-1:0] txByte;
	logic txReady;
	logic rxRead;
	logic [periphPkg::dataWidth-1:0] rxByte;
	logic rxValid;
	logic overrun;
	logic frameErr;
	logic dutyWrite;
	logic [periphPkg::dataWidth-1:0] dutyValue;
	logic pwmIrq;
	logic irqEnWrite;
	logic [periphPkg::irqCount-1:0] irqEnValue;

	// Host side decode and handshake
	regBus bus (.clk, .reset, .req, .write, .addr, .wdata, .ack, .rdata,
		.txWrite, .txByte, .txReady, .rxRead, .rxByte, .rxValid, .overrun,
		.frameErr, .dutyWrite, .dutyValue, .pwmIrq, .irqEnWrite, .irqEnValue);

	////////////////////////////////////////////////////////////
	// Peripherals

	uartTx #(.clkDiv(clkDiv)) tx (.clk, .reset, .txWrite, .txByte, .txReady, .txd);

	uartRx #(.clkDiv(clkDiv)) rx (.clk, .reset, .rxd, .rxRead,
		.rxByte, .rxValid, .overrun, .frameErr);

	pwmTimer #(.pwmMax(pwmMax)) pwm (.clk, .reset, .dutyWrite, .dutyValue,
		.pwmOut, .pwmIrq);

	// Interrupt request pin and source number
	irqUnit irqCtl (.clk, .reset, .irqEnWrite, .irqEnValue,
		.rxValid, .txReady, .pwmIrq, .irq, .irqId);

endmodule

// File: design/pwmTimer.sv
module pwmTimer #(
	parameter int pwmMax = 180	// Terminal count
) (
	input  logic clk,
	input  logic reset,
	input  logic dutyWrite,
	input  logic [periphPkg::dataWidth-1:0] dutyValue,
	output logic pwmOut,
	output logic pwmIrq
);

	localparam logic [periphPkg::dataWidth-1:0] countLast =
		pwmMax[periphPkg::dataWidth-1:0];

	logic [periphPkg::dataWidth-1:0] pwmCount;
	logic [periphPkg::dataWidth-1:0] dutyPending;	// Written by host
	logic [periphPkg::dataWidth-1:0] dutyBuf;		// Active this period
	logic termCount;
	logic zeroCount;

	assign termCount = pwmCount == countLast;
	assign zeroCount = pwmCount == '0;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pwmCount <= '0;
			dutyPending <= '0;
			dutyBuf <= '0;
			pwmOut <= 1'b0;
			pwmIrq <= 1'b0;
		end else begin
			pwmCount <= termCount ? '0 : pwmCount + 1'b1;	// Period of pwmMax+1
			if (dutyWrite) dutyPending <= dutyValue;
			if (termCount) dutyBuf <= dutyPending;	// New duty at period boundary
			// Clear beats set so a duty of 0 stays low
			if (pwmCount == dutyBuf) pwmOut <= 1'b0;
			else if (zeroCount) pwmOut <= 1'b1;
			// Once per period, acknowledged by a duty write
			if (zeroCount) pwmIrq <= 1'b1;
			else if (dutyWrite) pwmIrq <= 1'b0;
		end
	end

endmodule

// File: design/regBus.sv
module regBus (
	input  logic clk,
	input  logic reset,
	input  logic req,
	input  logic write,
	input  logic [periphPkg::addrWidth-1:0] addr,
	input  logic [periphPkg::dataWidth-1:0] wdata,
	output logic ack,
	output logic [periphPkg::dataWidth-1:0] rdata,
	output logic txWrite,
	output logic [periphPkg::dataWidth-1:0] txByte,
	input  logic txReady,
	output logic rxRead,
	input  logic [periphPkg::dataWidth-1:0] rxByte,
	input  logic rxValid,
	input  logic overrun,
	input  logic frameErr,
	output logic dutyWrite,
	output logic [periphPkg::dataWidth-1:0] dutyValue,
	input  logic pwmIrq,
	output logic irqEnWrite,
	output logic [periphPkg::irqCount-1:0] irqEnValue
);

	localparam logic [1:0] sIdle = 2'd0;	// Waiting for req
	localparam logic [1:0] sAcked = 2'd1;	// Strobe cycle
	localparam logic [1:0] sWaitLow = 2'd2;	// Ack held until req drops

	logic [1:0] state;
	logic isData;
	logic stall;
	logic accept;
	logic [periphPkg::dataWidth-1:0] statusWord;
	logic [periphPkg::dataWidth-1:0] readWord;
	logic [periphPkg::dataWidth-1:0] dutyShadow;		// Pending duty copy
	logic [periphPkg::irqCount-1:0] irqEnShadow;

	// Data register stalls on busy tx or empty rx
	assign isData = addr == periphPkg::regData;
	assign stall = isData & (write ? ~txReady : ~rxValid);
	assign accept = (state == sIdle) & req & ~stall;
	assign ack = state != sIdle;

	// wdata stays stable until the host sees ack
	assign txByte = wdata;
	assign dutyValue = wdata;
	assign irqEnValue = wdata[periphPkg::irqCount-1:0];

	////////////////////////////////////////////////////////////
	// Handshake FSM and strobes

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= sIdle;
			txWrite <= 1'b0;
			rxRead <= 1'b0;
			dutyWrite <= 1'b0;
			irqEnWrite <= 1'b0;
			dutyShadow <= '0;
			irqEnShadow <= '0;
		end else begin
			// One-cycle pulses, aligned with ack rising
			txWrite <= accept & write & isData;
			rxRead <= accept & ~write & isData;
			dutyWrite <= accept & write & (addr == periphPkg::regDuty);
			irqEnWrite <= accept & write & (addr == periphPkg::regIrqEnable);
			if (accept & write & (addr == periphPkg::regDuty)) dutyShadow <= wdata;
			if (accept & write & (addr == periphPkg::regIrqEnable)) irqEnShadow <= irqEnValue;
			case (state)
				sIdle: if (accept) state <= sAcked;
				sAcked: state <= req ? sWaitLow : sIdle;
				sWaitLow: if (!req) state <= sIdle;	// Ack drops next clock
				default: state <= sIdle;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Read path

	always_comb begin
		statusWord = '0;
		statusWord[periphPkg::stRxValid] = rxValid;
		statusWord[periphPkg::stTxReady] = txReady;
		statusWord[periphPkg::stFrameErr] = frameErr;
		statusWord[periphPkg::stOverrun] = overrun;
		statusWord[periphPkg::stPwmIrq] = pwmIrq;
		readWord = '0;
		case (addr)
			periphPkg::regData: readWord = rxByte;
			periphPkg::regStatus: readWord = statusWord;
			periphPkg::regDuty: readWord = dutyShadow;
			default: readWord[periphPkg::irqCount-1:0] = irqEnShadow;
		endcase
	end

	// Captured before the flags clear
	always_ff @(posedge clk)
		if (accept) rdata <= readWord;

	// Req still high when ack rises
	ackNeedsReq: assert property (@(posedge clk) disable iff (reset)
		$rose(ack) |-> req);

endmodule

// File: design/uartRx.sv
module uartRx #(
	parameter int clkDiv = 217	// Clocks per bit
) (
	input  logic clk,
	input  logic reset,
	input  logic rxd,
	input  logic rxRead,
	output logic [periphPkg::dataWidth-1:0] rxByte,
	output logic rxValid,
	output logic overrun,
	output logic frameErr
);

	localparam int divBits = $clog2(clkDiv);
	localparam logic [divBits-1:0] divLast = divBits'(clkDiv - 1);
	localparam logic [divBits-1:0] divMid = divBits'(clkDiv / 2 - 1);

	logic [1:0] rxSync;			// Two-stage synchronizer
	logic [divBits-1:0] rxDiv;
	logic [periphPkg::dataWidth+1:0] rxShift;	// Start, data, stop
	logic stopBit;
	logic [1:0] rxHist;			// Overrun and valid
	logic lineEdge;
	logic sample;
	logic done;

	assign lineEdge = rxSync[1] ^ rxSync[0];
	assign sample = rxDiv == divMid;	// Mid-bit
	assign done = ~rxShift[0];		// Start bit reached the bottom

	always_ff @(posedge clk or posedge reset) begin
		if (reset) rxSync <= 2'b11;
		else rxSync <= {rxSync[0], rxd};
	end

	// Realigned on every line edge
	always_ff @(posedge clk or posedge reset) begin
		if (reset) rxDiv <= '0;
		else if (lineEdge | (rxDiv == divLast)) rxDiv <= '0;
		else rxDiv <= rxDiv + 1'b1;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rxShift <= '1;
			stopBit <= 1'b1;
			rxHist <= 2'b00;
		end else begin
			if (done) rxShift <= '1;	// Rearm for next frame
			else if (sample) rxShift <= {rxSync[1], rxShift[periphPkg::dataWidth+1:1]};
			if (done) stopBit <= rxShift[periphPkg::dataWidth+1];
			// Completion wins over a read in the same cycle
			if (done) rxHist <= {rxHist[0], 1'b1};
			else if (rxRead) rxHist <= 2'b00;
		end
	end

	always_ff @(posedge clk)
		if (done) rxByte <= rxShift[periphPkg::dataWidth:1];

	assign rxValid = rxHist[0];
	assign overrun = rxHist[1];
	assign frameErr = ~stopBit;	// Stop bit sampled low

endmodule

// File: design/uartTx.sv
module uartTx #(
	parameter int clkDiv = 217	// Clocks per bit
) (
	input  logic clk,
	input  logic reset,
	input  logic txWrite,
	input  logic [periphPkg::dataWidth-1:0] txByte,
	output logic txReady,
	output logic txd
);

	localparam int divBits = $clog2(clkDiv);
	localparam logic [divBits-1:0] divLast = divBits'(clkDiv - 1);

	logic [divBits-1:0] txDiv;		// Baud divider
	logic [periphPkg::dataWidth:0] txShift;	// Data plus start bit
	logic [3:0] bitCount;			// Bits left, 0 when idle
	logic divMax;
	logic busy;

	assign divMax = txDiv == divLast;
	assign busy = |bitCount;
	assign txReady = ~busy;
	assign txd = txShift[0];

	// Restarts on write so the start bit gets a full bit time
	always_ff @(posedge clk or posedge reset) begin
		if (reset) txDiv <= '0;
		else if (txWrite | divMax) txDiv <= '0;
		else txDiv <= txDiv + 1'b1;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			txShift <= '1;	// Line idles high
			bitCount <= '0;
		end else if (txWrite) begin
			txShift <= {txByte, 1'b0};
			bitCount <= 4'd10;	// Start, 8 data, stop
		end else if (divMax) begin
			txShift <= {1'b1, txShift[periphPkg::dataWidth:1]};	// Ones fill in the stop bit
			if (busy) bitCount <= bitCount - 1'b1;
		end
	end

	// Host port stall must hold writes off a busy transmitter
	noWriteWhenBusy: assert property (@(posedge clk) disable iff (reset)
		txWrite |-> txReady);

endmodule

// File: src.f
design/periphPkg.sv
design/regBus.sv
design/uartTx.sv
design/uartRx.sv
design/pwmTimer.sv
design/irqUnit.sv
design/periphTop.sv
test/periphChecker.sv
test/periphTb.sv

// File: test/periphChecker.sv
module periphChecker #(
	parameter int clkDiv = 8,	// Clocks per serial bit
	parameter int pwmMax = 20
) (
	input  logic clk,
	input  logic reset,
	input  logic txd,
	input  logic pwmOut
);

	int errors;
	int checks;
	logic [7:0] txQueue[$];		// Bytes the host wrote
	logic [7:0] txWord;

	initial begin
		errors = 0;
		checks = 0;
	end

	task automatic checkByte(input string what, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic checkTrue(input string what, input logic cond);
		checks++;
		if (cond !== 1'b1) begin
			errors++;
			$display("Error at %0t: %s failed", $time, what);
		end
	endtask

	task automatic expectTx(input logic [7:0] b);
		txQueue.push_back(b);
	endtask

	function automatic int txLeft();
		return txQueue.size();
	endfunction

	// Any pwmMax+1 clock window covers one whole period
	task automatic measurePwm(input int expHigh);
		int high;
		high = 0;
		repeat (pwmMax + 1) begin
			@(posedge clk);
			if (pwmOut) high++;
		end
		checkByte("pwm high clocks", 8'(high), 8'(expHigh));
	endtask

	////////////////////////////////////////////////////////////
	// Transmit line decoder

	initial begin
		@(negedge reset);
		forever begin
			@(posedge clk);
			if (!txd) begin
				repeat (clkDiv / 2 - 1) @(posedge clk);	// Middle of start bit
				checkTrue("tx start bit low", !txd);
				for (int i = 0; i < 8; i++) begin
					repeat (clkDiv) @(posedge clk);
					txWord[i] = txd;
				end
				repeat (clkDiv) @(posedge clk);
				checkTrue("tx stop bit high", txd);
				if (txQueue.size() == 0) begin
					errors++;
					$display("A frame appeared on txd with no byte written");
				end else checkByte("tx byte", txWord, txQueue.pop_front());
			end
		end
	end

endmodule

// File: test/periphTb.sv
module periphTb;

	localparam int clkDiv = 8;
	localparam int pwmMax = 20;
	localparam int period = pwmMax + 1;
	localparam int busLimit = 20 * clkDiv;	// Longest legal stall plus slack
	localparam int frameClocks = 12 * clkDiv;	// Frame plus idle gap
	// Tx and rx frames, PWM windows, bus traffic
	localparam int runClocks = 24 * frameClocks + 16 * period + 2000;

	logic clk;
	logic reset;
	logic req;
	logic write;
	logic [periphPkg::addrWidth-1:0] addr;
	logic [periphPkg::dataWidth-1:0] wdata;
	logic ack;
	logic [periphPkg::dataWidth-1:0] rdata;
	logic rxd;
	logic txd;
	logic pwmOut;
	logic irq;
	logic [1:0] irqId;
	int seed;
	int waited;
	logic [7:0] got;
	logic [7:0] b;
	logic [7:0] b2;
	time stopStart;
	time readDone;

	periphTop #(.clkDiv(clkDiv), .pwmMax(pwmMax)) dut (.clk, .reset, .req, .write, .addr,
		.wdata, .ack, .rdata, .rxd, .txd, .pwmOut, .irq, .irqId);

	periphChecker #(.clkDiv(clkDiv), .pwmMax(pwmMax)) chk (.clk, .reset, .txd, .pwmOut);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	////////////////////////////////////////////////////////////
	// Reference model

	function automatic logic [7:0] expStatus(input logic rxV, txR, fErr, ovr, pIrq);
		logic [7:0] s;
		s = '0;
		s[periphPkg::stRxValid] = rxV;
		s[periphPkg::stTxReady] = txR;
		s[periphPkg::stFrameErr] = fErr;
		s[periphPkg::stOverrun] = ovr;
		s[periphPkg::stPwmIrq] = pIrq;
		return s;
	endfunction

	function automatic int pwmHighTime(input int duty);
		return (duty > pwmMax) ? period : duty;	// Above terminal count stays high
	endfunction

	// Rx first, then tx, then PWM
	function automatic logic [1:0] expIrqId(input logic [2:0] en, input logic rxV, txR, pIrq);
		if (en[0] && rxV) return 2'd1;
		if (en[1] && txR) return 2'd2;
		if (en[2] && pIrq) return 2'd3;
		return 2'd0;
	endfunction

	////////////////////////////////////////////////////////////
	// Host bus and serial line

	task automatic busAccess(input logic wr, input logic [1:0] a, input logic [7:0] d,
			output logic [7:0] q, output int clocks);
		@(posedge clk);
		req <= 1'b1;
		write <= wr;
		addr <= a;
		wdata <= d;
		clocks = 0;
		do begin
			@(posedge clk);
			clocks++;
		end while (!ack && clocks < busLimit);
		if (!ack) chk.checkTrue("bus access got no ack", 1'b0);
		q = rdata;	// Valid while ack is high
		req <= 1'b0;
		while (ack) @(posedge clk);
	endtask

	task automatic writeReg(input logic [1:0] a, input logic [7:0] d);
		logic [7:0] unused;
		int clocks;
		busAccess(1'b1, a, d, unused, clocks);
	endtask

	task automatic readReg(input logic [1:0] a, output logic [7:0] q);
		int clocks;
		busAccess(1'b0, a, 8'd0, q, clocks);
	endtask

	// PWM flag left out, its phase is free running
	task automatic checkStatus(input logic rxV, fErr, ovr);
		logic [7:0] s;
		readReg(periphPkg::regStatus, s);
		chk.checkByte("status", s & ~(8'd1 << periphPkg::stPwmIrq),
			expStatus(rxV, 1'b1, fErr, ovr, 1'b0));
	endtask

	task automatic sendFrame(input logic [7:0] d, input logic stopBit);
		logic [9:0] bits;
		bits = {stopBit, d, 1'b0};	// LSB first after start
		@(posedge clk);
		for (int i = 0; i < 10; i++) begin
			if (i == 9) stopStart = $time;
			rxd <= bits[i];
			repeat (clkDiv) @(posedge clk);
		end
		rxd <= 1'b1;
		repeat (2 * clkDiv) @(posedge clk);	// Idle gap
	endtask

	// Watchdog
	initial begin
		repeat (runClocks) @(posedge clk);
		$display("Timeout, the run did not finish within %0d clocks", runClocks);
		$display("** FAIL **");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		seed = 88;
		reset = 1'b1;
		req = 1'b0;
		write = 1'b0;
		addr = '0;
		wdata = '0;
		rxd = 1'b1;
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		checkStatus(1'b0, 1'b0, 1'b0);	// Out of reset
		chk.checkTrue("irq low after reset", !irq);

		// Back to back writes stall on the busy transmitter
		for (int i = 0; i < 8; i++) begin
			b = 8'($random(seed));
			chk.expectTx(b);
			busAccess(1'b1, periphPkg::regData, b, got, waited);
			if (i > 0) chk.checkTrue("write while busy delays ack", waited > 8 * clkDiv);
		end
		repeat (11 * clkDiv) @(posedge clk);
		chk.checkTrue("all tx bytes seen on txd", chk.txLeft() == 0);

		// Read issued before the frame arrives
		b = 8'($random(seed));
		fork
			sendFrame(b, 1'b1);
			begin
				readReg(periphPkg::regData, got);
				readDone = $time;
			end
		join
		chk.checkByte("rx byte", got, b);
		chk.checkTrue("rx read waits for frame", readDone > stopStart);
		checkStatus(1'b0, 1'b0, 1'b0);
		for (int i = 0; i < 3; i++) begin
			b = 8'($random(seed));
			sendFrame(b, 1'b1);
			readReg(periphPkg::regData, got);
			chk.checkByte("rx byte", got, b);
			checkStatus(1'b0, 1'b0, 1'b0);
		end

		// Framing error, then overrun
		sendFrame(8'($random(seed)), 1'b0);
		checkStatus(1'b1, 1'b1, 1'b0);
		readReg(periphPkg::regData, got);
		b = 8'($random(seed));
		b2 = 8'($random(seed));
		sendFrame(b, 1'b1);
		sendFrame(b2, 1'b1);
		checkStatus(1'b1, 1'b0, 1'b1);
		readReg(periphPkg::regData, got);
		chk.checkByte("rx byte after overrun", got, b2);	// Newest frame kept
		checkStatus(1'b0, 1'b0, 1'b0);

		// PWM duty sweep
		for (int k = 0; k < 3; k++) begin
			b = (k == 0) ? 8'd0 : (k == 1) ? 8'd7 : 8'd20;
			writeReg(periphPkg::regDuty, b);
			repeat (2 * period) @(posedge clk);	// Settle into the new duty
			chk.measurePwm(pwmHighTime(b));
			readReg(periphPkg::regDuty, got);
			chk.checkByte("duty readback", got, b);
		end

		// PWM flag cleared by a write early in the period
		writeReg(periphPkg::regDuty, 8'd7);
		repeat (2 * period) @(posedge clk);
		@(posedge pwmOut);
		writeReg(periphPkg::regDuty, 8'd7);
		readReg(periphPkg::regStatus, got);
		chk.checkTrue("pwm flag cleared by duty write", !got[periphPkg::stPwmIrq]);
		repeat (period + 2) @(posedge clk);
		readReg(periphPkg::regStatus, got);
		chk.checkTrue("pwm flag set each period", got[periphPkg::stPwmIrq]);

		// Interrupt priority
		sendFrame(8'($random(seed)), 1'b1);
		writeReg(periphPkg::regIrqEnable, 8'h07);
		@(posedge clk);
		chk.checkByte("irqId rx pending", 8'(irqId), 8'(expIrqId(3'b111, 1'b1, 1'b1, 1'b1)));
		chk.checkTrue("irq with rx pending", irq);
		readReg(periphPkg::regData, got);
		writeReg(periphPkg::regIrqEnable, 8'h03);
		@(posedge clk);
		chk.checkByte("irqId tx ready", 8'(irqId), 8'(expIrqId(3'b011, 1'b0, 1'b1, 1'b1)));
		writeReg(periphPkg::regIrqEnable, 8'h04);
		@(posedge clk);
		chk.checkByte("irqId pwm only", 8'(irqId), 8'(expIrqId(3'b100, 1'b0, 1'b1, 1'b1)));
		writeReg(periphPkg::regIrqEnable, 8'h00);
		@(posedge clk);
		chk.checkTrue("irq low with sources disabled", !irq);
		chk.checkByte("irqId none", 8'(irqId), 8'(expIrqId(3'b000, 1'b0, 1'b1, 1'b1)));

		$display("Checks %0d, errors %0d", chk.checks, chk.errors);
		if (chk.errors == 0) $display("** PASS **");
		else $display("** FAIL **");
		$finish;
	end

endmodule
